// ==== logic/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

	localparam int XLEN = 32;

	typedef enum logic [6:0] {
		OP_LOAD   = 7'b0000011,
		OP_IMM    = 7'b0010011,
		OP_AUIPC  = 7'b0010111,
		OP_STORE  = 7'b0100011,
		OP_REG    = 7'b0110011,
		OP_LUI    = 7'b0110111,
		OP_BRANCH = 7'b1100011,
		OP_JALR   = 7'b1100111,
		OP_JAL    = 7'b1101111
	} opcode_e;

	// branch conditions
	localparam logic [2:0] F3_BEQ  = 3'd0;
	localparam logic [2:0] F3_BNE  = 3'd1;
	localparam logic [2:0] F3_BLT  = 3'd4;
	localparam logic [2:0] F3_BGE  = 3'd5;
	localparam logic [2:0] F3_BLTU = 3'd6;
	localparam logic [2:0] F3_BGEU = 3'd7;

	// load and store access size
	localparam logic [2:0] F3_B  = 3'd0;
	localparam logic [2:0] F3_H  = 3'd1;
	localparam logic [2:0] F3_W  = 3'd2;
	localparam logic [2:0] F3_BU = 3'd4;
	localparam logic [2:0] F3_HU = 3'd5;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_e    opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		opcode_e     opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		opcode_e    opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		opcode_e    opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		opcode_e     opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		opcode_e    opcode;
	} j_fmt_t;

	typedef union packed {
		logic [XLEN-1:0] raw;
		r_fmt_t          r_fmt;
		i_fmt_t          i_fmt;
		s_fmt_t          s_fmt;
		b_fmt_t          b_fmt;
		u_fmt_t          u_fmt;
		j_fmt_t          j_fmt;
	} instr_u;

endpackage

`default_nettype wire

// ==== logic/core_ctrl_pkg.sv ====
`default_nettype none

package core_ctrl_pkg;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
		ALU_EQ, ALU_NE, ALU_GE, ALU_GEU
	} alu_op_e;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_FETCH,
		ST_EXECUTE,
		ST_WRITEBACK
	} core_state_e;

	typedef enum logic [2:0] {
		WB_NONE,
		WB_ALU,
		WB_MEM,
		WB_PC4,
		WB_IMM
	} wb_sel_e;

	typedef struct packed {
		alu_op_e    alu_op;
		logic       b_is_imm;
		logic       a_is_pc;
		wb_sel_e    wb_sel;
		logic       is_branch;
		logic       is_jump;   // jal and jalr, target comes from the ALU
		logic       mem_we;
		logic       mem_re;
		logic [2:0] funct3;
	} ctrl_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [4:0]  rd;
		logic        we;
		logic [31:0] data;
	} retire_t;

endpackage

`default_nettype wire

// ==== logic/step_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module step_timer #(
	parameter int STEP_DIV = 4
) (
	input  logic clk,
	input  logic rstn,
	input  logic run_i,
	output logic step_o
);
	localparam int CW = (STEP_DIV > 1) ? $clog2(STEP_DIV) : 1;

	logic [CW-1:0] cnt_q;
	logic          wrap;

	assign wrap = cnt_q == CW'(STEP_DIV - 1);
	assign step_o = run_i && wrap;

	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
			cnt_q <= '0;
		else if (!run_i || wrap)
			cnt_q <= '0;   // stopped or period done
		else
			cnt_q <= cnt_q + 1'b1;
	end

	generate
		if (STEP_DIV > 1)
		begin : g_pulse_chk
			a_step_single: assert property (@(posedge clk) disable iff (!rstn)
				step_o |=> !step_o);
		end
	endgenerate

endmodule

`default_nettype wire

// ==== logic/core_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_fsm (
	input  logic                         clk,
	input  logic                         rstn,
	input  logic                         run_i,
	input  logic                         step_i,
	input  core_ctrl_pkg::ctrl_t         ctrl_i,
	input  logic [rv_isa_pkg::XLEN-1:0]  imm_i,
	input  logic [rv_isa_pkg::XLEN-1:0]  alu_res_i,
	input  logic [rv_isa_pkg::XLEN-1:0]  mem_rdata_i,
	input  logic [4:0]                   rd_i,
	output logic                         fetch_o,
	output logic [rv_isa_pkg::XLEN-1:0]  pc_o,
	output logic                         rf_we_o,
	output logic [rv_isa_pkg::XLEN-1:0]  rf_wdata_o,
	output logic                         mem_we_o,
	output logic                         retire_valid_o,
	output core_ctrl_pkg::retire_t       retire_o
);
	import rv_isa_pkg::*;
	import core_ctrl_pkg::*;

	core_state_e     state_q;
	core_state_e     state_d;
	logic [XLEN-1:0] pc_q;
	logic [XLEN-1:0] alu_q;   // captured on the EXECUTE step
	logic            adv;
	logic            wb_step;
	logic            taken;

	// after run_i drops the open instruction completes without waiting for steps
	assign adv = step_i || (!run_i && state_q != ST_IDLE);
	assign wb_step = adv && state_q == ST_WRITEBACK;
	assign taken = ctrl_i.is_branch && alu_q[0];

	always_comb
	begin
		case (state_q)
			ST_IDLE:    state_d = run_i ? ST_FETCH : ST_IDLE;
			ST_FETCH:   state_d = ST_EXECUTE;
			ST_EXECUTE: state_d = ST_WRITEBACK;
			default:    state_d = run_i ? ST_FETCH : ST_IDLE;
		endcase
	end

	always_comb
	begin
		case (ctrl_i.wb_sel)
			WB_ALU:  rf_wdata_o = alu_q;
			WB_MEM:  rf_wdata_o = mem_rdata_i;
			WB_PC4:  rf_wdata_o = pc_q + 4;   // link
			WB_IMM:  rf_wdata_o = imm_i;
			default: rf_wdata_o = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			state_q <= ST_IDLE;
			pc_q <= '0;
		end
		else if (adv)
		begin
			state_q <= state_d;
			if (wb_step)
				pc_q <= ctrl_i.is_jump ? {alu_q[XLEN-1:1], 1'b0} :
					(taken ? pc_q + imm_i : pc_q + 4);
		end
	end

	always_ff @(posedge clk)
	begin
		if (adv && state_q == ST_EXECUTE)
			alu_q <= alu_res_i;
	end

	assign fetch_o = adv && state_q == ST_FETCH;
	assign pc_o = pc_q;
	assign rf_we_o = wb_step && ctrl_i.wb_sel != WB_NONE;
	assign mem_we_o = wb_step && ctrl_i.mem_we;
	assign retire_valid_o = wb_step;
	assign retire_o = '{pc: pc_q, rd: rd_i, we: ctrl_i.wb_sel != WB_NONE, data: rf_wdata_o};

	a_wr_in_wb: assert property (@(posedge clk) disable iff (!rstn)
		(rf_we_o || mem_we_o) |-> state_q == ST_WRITEBACK ##1 state_q != ST_WRITEBACK);

endmodule

`default_nettype wire

// ==== logic/instr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
	input  rv_isa_pkg::instr_u          instr_i,
	output logic [4:0]                  rs1_o,
	output logic [4:0]                  rs2_o,
	output logic [4:0]                  rd_o,
	output logic [rv_isa_pkg::XLEN-1:0] imm_o,
	output core_ctrl_pkg::ctrl_t        ctrl_o
);
	import rv_isa_pkg::*;
	import core_ctrl_pkg::*;

	logic [XLEN-1:0] i_imm;
	logic [XLEN-1:0] s_imm;
	logic [XLEN-1:0] b_imm;
	logic [XLEN-1:0] u_imm;
	logic [XLEN-1:0] j_imm;
	logic            is_reg;
	logic            sra_bit;
	alu_op_e         arith_op;
	alu_op_e         cmp_op;

	assign i_imm = {{20{instr_i.i_fmt.imm[11]}}, instr_i.i_fmt.imm};
	assign s_imm = {{20{instr_i.s_fmt.imm_hi[6]}}, instr_i.s_fmt.imm_hi, instr_i.s_fmt.imm_lo};
	assign b_imm = {{19{instr_i.b_fmt.imm12}}, instr_i.b_fmt.imm12, instr_i.b_fmt.imm11,
		instr_i.b_fmt.imm10_5, instr_i.b_fmt.imm4_1, 1'b0};
	assign u_imm = {instr_i.u_fmt.imm, 12'b0};
	assign j_imm = {{11{instr_i.j_fmt.imm20}}, instr_i.j_fmt.imm20, instr_i.j_fmt.imm19_12,
		instr_i.j_fmt.imm11, instr_i.j_fmt.imm10_1, 1'b0};

	assign rs1_o = instr_i.r_fmt.rs1;
	assign rs2_o = instr_i.r_fmt.rs2;
	assign rd_o = instr_i.r_fmt.rd;

	assign is_reg = instr_i.r_fmt.opcode == OP_REG;
	assign sra_bit = i_imm[10];   // word bit 30 in both formats

	always_comb
	begin
		case (instr_i.r_fmt.funct3)
			3'd0: arith_op = (is_reg && instr_i.r_fmt.funct7[5]) ? ALU_SUB : ALU_ADD;
			3'd1: arith_op = ALU_SLL;
			3'd2: arith_op = ALU_SLT;
			3'd3: arith_op = ALU_SLTU;
			3'd4: arith_op = ALU_XOR;
			3'd5: arith_op = sra_bit ? ALU_SRA : ALU_SRL;
			3'd6: arith_op = ALU_OR;
			default: arith_op = ALU_AND;
		endcase
		case (instr_i.b_fmt.funct3)
			F3_BNE:  cmp_op = ALU_NE;
			F3_BLT:  cmp_op = ALU_SLT;
			F3_BGE:  cmp_op = ALU_GE;
			F3_BLTU: cmp_op = ALU_SLTU;
			F3_BGEU: cmp_op = ALU_GEU;
			default: cmp_op = ALU_EQ;
		endcase
	end

	always_comb
	begin
		ctrl_o = '0;
		ctrl_o.alu_op = ALU_ADD;
		ctrl_o.funct3 = instr_i.r_fmt.funct3;
		imm_o = i_imm;
		case (instr_i.r_fmt.opcode)
			OP_REG:
			begin
				ctrl_o.alu_op = arith_op;
				ctrl_o.wb_sel = WB_ALU;
			end
			OP_IMM:
			begin
				ctrl_o.alu_op = arith_op;
				ctrl_o.b_is_imm = 1'b1;
				ctrl_o.wb_sel = WB_ALU;
			end
			OP_LOAD:
			begin
				ctrl_o.b_is_imm = 1'b1;
				ctrl_o.mem_re = 1'b1;
				ctrl_o.wb_sel = WB_MEM;
			end
			OP_STORE:
			begin
				ctrl_o.b_is_imm = 1'b1;
				ctrl_o.mem_we = 1'b1;
				imm_o = s_imm;
			end
			OP_BRANCH:
			begin
				ctrl_o.alu_op = cmp_op;
				ctrl_o.is_branch = 1'b1;
				imm_o = b_imm;
			end
			OP_JAL:
			begin
				ctrl_o.a_is_pc = 1'b1;
				ctrl_o.b_is_imm = 1'b1;
				ctrl_o.is_jump = 1'b1;
				ctrl_o.wb_sel = WB_PC4;
				imm_o = j_imm;
			end
			OP_JALR:
			begin
				ctrl_o.b_is_imm = 1'b1;
				ctrl_o.is_jump = 1'b1;
				ctrl_o.wb_sel = WB_PC4;
			end
			OP_LUI:
			begin
				ctrl_o.wb_sel = WB_IMM;
				imm_o = u_imm;
			end
			OP_AUIPC:
			begin
				ctrl_o.a_is_pc = 1'b1;
				ctrl_o.b_is_imm = 1'b1;
				ctrl_o.wb_sel = WB_ALU;
				imm_o = u_imm;
			end
			default: ctrl_o.wb_sel = WB_NONE;   // retires with no write
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic                        clk,
	input  logic                        rstn,
	input  logic                        we_i,
	input  logic [4:0]                  waddr_i,
	input  logic [rv_isa_pkg::XLEN-1:0] wdata_i,
	input  logic [4:0]                  raddr1_i,
	input  logic [4:0]                  raddr2_i,
	output logic [rv_isa_pkg::XLEN-1:0] rdata1_o,
	output logic [rv_isa_pkg::XLEN-1:0] rdata2_o
);
	import rv_isa_pkg::*;

	logic [XLEN-1:0] regs_q [32];   // x0 cleared by reset only

	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			for (int i = 0; i < 32; i++)
				regs_q[i] <= '0;
		end
		else if (we_i && waddr_i != 5'd0)
			regs_q[waddr_i] <= wdata_i;
	end

	assign rdata1_o = regs_q[raddr1_i];
	assign rdata2_o = regs_q[raddr2_i];

	// entry 0 stays clear as long as x0 writes are dropped
	a_x0_zero: assert property (@(posedge clk) disable iff (!rstn)
		raddr1_i == 5'd0 |-> rdata1_o == '0);

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  core_ctrl_pkg::alu_op_e      op_i,
	input  logic [rv_isa_pkg::XLEN-1:0] a_i,
	input  logic [rv_isa_pkg::XLEN-1:0] b_i,
	output logic [rv_isa_pkg::XLEN-1:0] y_o
);
	import rv_isa_pkg::*;
	import core_ctrl_pkg::*;

	logic [4:0] shamt;
	logic       lt_s;
	logic       lt_u;

	assign shamt = b_i[4:0];
	assign lt_s = $signed(a_i) < $signed(b_i);
	assign lt_u = a_i < b_i;

	always_comb
	begin
		case (op_i)
			ALU_ADD:  y_o = a_i + b_i;
			ALU_SUB:  y_o = a_i - b_i;
			ALU_SLL:  y_o = a_i << shamt;
			ALU_SLT:  y_o = XLEN'(lt_s);
			ALU_SLTU: y_o = XLEN'(lt_u);
			ALU_XOR:  y_o = a_i ^ b_i;
			ALU_SRL:  y_o = a_i >> shamt;
			ALU_SRA:  y_o = $signed(a_i) >>> shamt;
			ALU_OR:   y_o = a_i | b_i;
			ALU_AND:  y_o = a_i & b_i;
			ALU_EQ:   y_o = XLEN'(a_i == b_i);   // branch compares
			ALU_NE:   y_o = XLEN'(a_i != b_i);
			ALU_GE:   y_o = XLEN'(!lt_s);
			ALU_GEU:  y_o = XLEN'(!lt_u);
			default:  y_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
	parameter int DEPTH_WORDS = 256
) (
	input  logic                        clk,
	input  logic                        rstn,
	input  logic                        we_i,
	input  logic [rv_isa_pkg::XLEN-1:0] addr_i,
	input  logic [2:0]                  funct3_i,
	input  logic [rv_isa_pkg::XLEN-1:0] wdata_i,
	output logic [rv_isa_pkg::XLEN-1:0] rdata_o
);
	import rv_isa_pkg::*;

	localparam int AW = $clog2(DEPTH_WORDS);

	logic [XLEN-1:0] mem [DEPTH_WORDS];
	logic [AW-1:0]   idx;
	logic [1:0]      lane;
	logic [3:0]      be;
	logic [XLEN-1:0] wlane;
	logic [XLEN-1:0] rword;

	assign idx = addr_i[AW+1:2];
	assign lane = addr_i[1:0];
	assign wlane = wdata_i << {lane, 3'b000};
	assign rword = mem[idx] >> {lane, 3'b000};   // addressed lane moved to bit 0

	always_comb
	begin
		case (funct3_i)
			F3_B:    be = 4'b0001 << lane;
			F3_H:    be = 4'b0011 << lane;
			default: be = 4'b1111;
		endcase
	end

	always_ff @(posedge clk)
	begin
		for (int b = 0; b < 4; b++)
			if (we_i && be[b])
				mem[idx][8*b +: 8] <= wlane[8*b +: 8];
	end

	always_comb
	begin
		case (funct3_i)
			F3_B:    rdata_o = {{24{rword[7]}}, rword[7:0]};
			F3_H:    rdata_o = {{16{rword[15]}}, rword[15:0]};
			F3_BU:   rdata_o = {24'b0, rword[7:0]};
			F3_HU:   rdata_o = {16'b0, rword[15:0]};
			default: rdata_o = rword;
		endcase
	end

	a_st_aligned: assert property (@(posedge clk) disable iff (!rstn)
		we_i |-> (funct3_i == F3_W ? lane == 2'b00 : (funct3_i != F3_H || !lane[0])));

endmodule

`default_nettype wire

// ==== logic/instr_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_ram #(
	parameter int DEPTH_WORDS = 256
) (
	input  logic                           clk,
	input  logic                           load_we_i,
	input  logic [$clog2(DEPTH_WORDS)-1:0] load_addr_i,
	input  logic [rv_isa_pkg::XLEN-1:0]    load_data_i,
	input  logic [rv_isa_pkg::XLEN-1:0]    pc_i,
	output rv_isa_pkg::instr_u             instr_o
);
	import rv_isa_pkg::*;

	localparam int AW = $clog2(DEPTH_WORDS);

	instr_u mem [DEPTH_WORDS];

	always_ff @(posedge clk)
	begin
		if (load_we_i)
			mem[load_addr_i].raw <= load_data_i;   // word address
	end

	assign instr_o = mem[pc_i[AW+1:2]];

endmodule

`default_nettype wire

// ==== logic/rv_step_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_step_core #(
	parameter int STEP_DIV   = 4,
	parameter int IMEM_WORDS = 256,
	parameter int DMEM_WORDS = 256
) (
	input  logic                          clk,
	input  logic                          rstn,
	input  logic                          run_i,
	input  logic                          load_we_i,
	input  logic [$clog2(IMEM_WORDS)-1:0] load_addr_i,
	input  logic [rv_isa_pkg::XLEN-1:0]   load_data_i,
	output logic                          retire_valid_o,
	output core_ctrl_pkg::retire_t        retire_o
);
	import rv_isa_pkg::*;
	import core_ctrl_pkg::*;

	logic            step;
	logic            fetch;
	logic [XLEN-1:0] pc;
	instr_u          instr_rd;
	instr_u          instr_q;
	logic [4:0]      rs1;
	logic [4:0]      rs2;
	logic [4:0]      rd;
	logic [XLEN-1:0] imm;
	ctrl_t           ctrl;
	logic [XLEN-1:0] rdata1;
	logic [XLEN-1:0] rdata2;
	logic [XLEN-1:0] alu_a;
	logic [XLEN-1:0] alu_b;
	logic [XLEN-1:0] alu_y;
	logic [XLEN-1:0] mem_rdata;
	logic [XLEN-1:0] rf_wdata;
	logic            rf_we;
	logic            mem_we;

	// word stays put from the FETCH step until the next one
	always_ff @(posedge clk)
	begin
		if (fetch)
			instr_q <= instr_rd;
	end

	assign alu_a = ctrl.a_is_pc ? pc : rdata1;
	assign alu_b = ctrl.b_is_imm ? imm : rdata2;

	step_timer #(.STEP_DIV(STEP_DIV)) i_step_timer (
		.clk(clk), .rstn(rstn), .run_i(run_i), .step_o(step)
	);

	instr_ram #(.DEPTH_WORDS(IMEM_WORDS)) i_instr_ram (
		.clk(clk), .load_we_i(load_we_i && !run_i), .load_addr_i(load_addr_i),
		.load_data_i(load_data_i), .pc_i(pc), .instr_o(instr_rd)
	);

	instr_decode i_instr_decode (
		.instr_i(instr_q), .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd), .imm_o(imm), .ctrl_o(ctrl)
	);

	reg_file i_reg_file (
		.clk(clk), .rstn(rstn), .we_i(rf_we), .waddr_i(rd), .wdata_i(rf_wdata),
		.raddr1_i(rs1), .raddr2_i(rs2), .rdata1_o(rdata1), .rdata2_o(rdata2)
	);

	alu i_alu (.op_i(ctrl.alu_op), .a_i(alu_a), .b_i(alu_b), .y_o(alu_y));

	data_ram #(.DEPTH_WORDS(DMEM_WORDS)) i_data_ram (
		.clk(clk), .rstn(rstn), .we_i(mem_we), .addr_i(alu_y), .funct3_i(ctrl.funct3),
		.wdata_i(rdata2), .rdata_o(mem_rdata)
	);

	core_fsm i_core_fsm (
		.clk(clk), .rstn(rstn), .run_i(run_i), .step_i(step), .ctrl_i(ctrl),
		.imm_i(imm), .alu_res_i(alu_y), .mem_rdata_i(mem_rdata), .rd_i(rd),
		.fetch_o(fetch), .pc_o(pc), .rf_we_o(rf_we), .rf_wdata_o(rf_wdata),
		.mem_we_o(mem_we), .retire_valid_o(retire_valid_o), .retire_o(retire_o)
	);

endmodule

`default_nettype wire

// ==== sim/tb_rv_step_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_step_core;
	import rv_isa_pkg::*;
	import core_ctrl_pkg::*;

	localparam int STEP_DIV = 4;
	localparam int PROG_LEN = 200;
	localparam int STEP_GAP = 3 * STEP_DIV;   // clocks between retires
	localparam int WATCHDOG_NS = (PROG_LEN + 20) * 3 * STEP_DIV * 8 * 2;
	localparam logic [31:0] DBASE = 32'h0000_1100;   // data window base, kept in x31

	logic        clk;
	logic        rstn;
	logic        run;
	logic        load_we;
	logic [7:0]  load_addr;
	logic [31:0] load_data;
	logic        retire_valid;
	retire_t     retire;

	integer      seed;
	logic [31:0] prog [PROG_LEN];
	logic [31:0] regs [32];
	logic [7:0]  dmem [256];   // byte image of the 64-word window
	bit          dvalid [256];
	retire_t     exp_q [$];
	int          cat_q [$];
	int          slot;
	int          pc_idx;
	int          checks [6];
	int          errors [6];
	string       names [6] = '{"reset_load", "arith", "control", "memory", "upper_zero",
		"step_rate"};
	int          cyc = 0;
	int          last_cyc = 0;
	int          n_ret = 0;
	bit          all_seen = 1'b0;

	rv_step_core #(.STEP_DIV(STEP_DIV), .IMEM_WORDS(256), .DMEM_WORDS(256)) i_rv_step_core (
		.clk(clk), .rstn(rstn), .run_i(run), .load_we_i(load_we), .load_addr_i(load_addr),
		.load_data_i(load_data), .retire_valid_o(retire_valid), .retire_o(retire)
	);

	always #4 clk = ~clk;

	function automatic int urand(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5:
			begin
				if (alt)
					return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic bit br_taken(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	// forward only, never past the closing self-jump
	function automatic int fwd_target();
		int span;
		span = PROG_LEN - 1 - slot;
		return slot + 1 + urand(span < 8 ? span : 8);
	endfunction

	task automatic push(input logic [31:0] w, input bit we, input logic [31:0] val,
		input int nxt, input int cat);
		retire_t r;
		r.pc = 32'(pc_idx * 4);
		r.rd = w[11:7];
		r.we = we;
		r.data = we ? val : 32'h0;
		prog[slot] = w;
		exp_q.push_back(r);
		cat_q.push_back((we && r.rd == 5'd0) ? 4 : cat);
		if (we && r.rd != 5'd0)
			regs[r.rd] = val;
		pc_idx = nxt;
	endtask

	task automatic gen_exec();
		logic [2:0]  f3;
		logic        alt;
		logic        u;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [4:0]  rd;
		logic [11:0] i12;
		logic [31:0] v;
		int          t;
		int          sz;
		int          off;
		bit          ok;
		f3 = 3'(urand(8));
		rs1 = 5'(urand(32));
		rs2 = 5'(urand(32));
		rd = 5'(urand(31));   // x31 stays the data base
		i12 = 12'(urand(4096));
		case (urand(10))
			0, 1:
			begin
				alt = (f3 == 3'd0 || f3 == 3'd5) && urand(2) == 1;
				push({1'b0, alt, 5'b0, rs2, rs1, f3, rd, OP_REG}, 1,
					alu_ref(f3, alt, regs[rs1], regs[rs2]), pc_idx + 1, 1);
			end
			2, 3:
			begin
				alt = f3 == 3'd5 && urand(2) == 1;
				if (f3 == 3'd1 || f3 == 3'd5)
					i12 = {1'b0, alt, 5'b0, i12[4:0]};   // shamt form
				v = {{20{i12[11]}}, i12};
				push({i12, rs1, f3, rd, OP_IMM}, 1, alu_ref(f3, alt, regs[rs1], v), pc_idx + 1, 1);
			end
			4:
			begin
				v = {20'(urand(1 << 20)), 12'b0};
				if (urand(2) == 1)
					push({v[31:12], rd, OP_LUI}, 1, v, pc_idx + 1, 4);
				else
					push({v[31:12], rd, OP_AUIPC}, 1, 32'(pc_idx * 4) + v, pc_idx + 1, 4);
			end
			5:
			begin
				t = fwd_target();
				if (f3[2:1] == 2'b01)
					f3 = {2'b00, f3[0]};   // no branch with funct3 2 or 3
				v = 32'((t - slot) * 4);
				push({v[12], v[10:5], rs2, rs1, f3, v[4:1], v[11], OP_BRANCH}, 0, 32'h0,
					br_taken(f3, regs[rs1], regs[rs2]) ? t : slot + 1, 2);
			end
			6:
			begin
				t = fwd_target();
				v = 32'((t - slot) * 4);
				push({v[20], v[10:1], v[11], v[19:12], rd, OP_JAL}, 1, 32'(slot * 4 + 4), t, 2);
			end
			7:
			begin
				t = fwd_target();
				v = 32'(t * 4) - regs[rs1];
				if ($signed(v) > 2047 || $signed(v) < -2048)
				begin
					rs1 = 5'd0;
					v = 32'(t * 4);
				end
				if (!v[0] && urand(2) == 1)
					v = v + 1;   // core clears bit 0
				push({v[11:0], rs1, 3'b000, rd, OP_JALR}, 1, 32'(slot * 4 + 4), t, 2);
			end
			default:
			begin
				sz = urand(3);
				off = urand(64) * 4 + (sz == 0 ? urand(4) : (sz == 1 ? urand(2) * 2 : 0));
				ok = urand(2) == 1;
				for (int b = 0; b < (1 << sz); b++)
					ok = ok && dvalid[off + b];   // load only bytes stored before
				if (ok)
				begin
					v = 32'h0;
					for (int b = 0; b < (1 << sz); b++)
						v[8*b +: 8] = dmem[off + b];
					u = sz < 2 && urand(2) == 1;
					if (!u && sz == 0)
						v = {{24{v[7]}}, v[7:0]};
					if (!u && sz == 1)
						v = {{16{v[15]}}, v[15:0]};
					push({12'(off), 5'd31, u, 2'(sz), rd, OP_LOAD}, 1, v, pc_idx + 1, 3);
				end
				else
				begin
					v = regs[rs2];
					for (int b = 0; b < (1 << sz); b++)
					begin
						dmem[off + b] = v[8*b +: 8];
						dvalid[off + b] = 1'b1;
					end
					push({7'(off >> 5), rs2, 5'd31, 3'(sz), 5'(off), OP_STORE}, 0, 32'h0,
						pc_idx + 1, 3);
				end
			end
		endcase
	endtask

	task automatic build_program();
		for (int i = 0; i < 32; i++)
			regs[i] = 32'h0;
		for (int i = 0; i < 256; i++)
			dvalid[i] = 1'b0;
		pc_idx = 0;
		slot = 0;
		push({20'h00001, 5'd31, OP_LUI}, 1, 32'h0000_1000, 1, 4);
		slot = 1;
		push({12'h100, 5'd31, 3'b000, 5'd31, OP_IMM}, 1, DBASE, 2, 1);
		for (slot = 2; slot < PROG_LEN - 1; slot++)
		begin
			if (pc_idx == slot)
				gen_exec();
			else
				prog[slot] = {7'b0, 5'(urand(32)), 5'(urand(32)), 3'(urand(8)), 5'(urand(31)),
					OP_REG};   // jumped over
		end
		push({20'h0, 5'd0, OP_JAL}, 1, 32'(slot * 4 + 4), slot, 2);   // self-jump
		push({20'h0, 5'd0, OP_JAL}, 1, 32'(slot * 4 + 4), slot, 2);
	endtask

	task automatic report(input int k);
		$display("test %-10s %0d checks, %0d errors, %s", names[k], checks[k], errors[k],
			errors[k] == 0 ? "ok" : "failing");
	endtask

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want,
		input logic [31:0] pc, input int cat);
		checks[cat]++;
		assert (got === want) else
		begin
			$display("[ERROR] %s got %h expected %h at pc %h", name, got, want, pc);
			errors[cat]++;
		end
	endtask

	task automatic check_retire();
		retire_t e;
		int      c;
		e = exp_q.pop_front();
		c = cat_q.pop_front();
		if (n_ret == 0)
		begin
			compare("retire_o.pc", retire.pc, 32'h0, e.pc, 0);
			report(0);
		end
		else
			compare("retire gap", 32'(cyc - last_cyc), 32'(STEP_GAP), e.pc, 5);
		compare("retire_o.pc", retire.pc, e.pc, e.pc, 2);
		compare("retire_o.rd", 32'(retire.rd), 32'(e.rd), e.pc, c);
		compare("retire_o.we", 32'(retire.we), 32'(e.we), e.pc, c);
		compare("retire_o.data", retire.data, e.data, e.pc, c);
		last_cyc = cyc;
		n_ret++;
		if (exp_q.size() == 0)
			all_seen = 1'b1;
	endtask

	// outputs settle after the rising edge, so they are sampled just before the next one
	always @(posedge clk)
	begin
		cyc++;
		if (!run)
		begin
			checks[0]++;
			assert (!retire_valid) else
			begin
				$display("retire strobe seen while the core was in reset or not running");
				errors[0]++;
			end
		end
		else if (retire_valid && !all_seen)
			check_retire();
	end

	initial
	begin
		int total_checks;
		int total_errors;
		clk = 1'b0;
		rstn = 1'b1;
		run = 1'b0;
		load_we = 1'b0;
		load_addr = '0;
		load_data = '0;
		seed = 32'h17a210da;
		build_program();
		#1 rstn = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;
		for (int i = 0; i < PROG_LEN; i++)
		begin
			@(negedge clk);
			load_we = 1'b1;
			load_addr = 8'(i);
			load_data = prog[i];
		end
		@(negedge clk);
		load_we = 1'b0;
		repeat (2) @(negedge clk);
		run = 1'b1;
		wait (all_seen);
		total_checks = 0;
		total_errors = 0;
		for (int k = 1; k < 6; k++)
			report(k);
		for (int k = 0; k < 6; k++)
		begin
			total_checks += checks[k];
			total_errors += errors[k];
		end
		$display("6 tests, %0d retires, %0d checks, %0d errors", n_ret, total_checks,
			total_errors);
		if (total_errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired, the core stopped retiring with %0d retires still expected",
			exp_q.size());
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rv_step_core.f ====
logic/rv_isa_pkg.sv
logic/core_ctrl_pkg.sv
logic/step_timer.sv
logic/core_fsm.sv
logic/instr_decode.sv
logic/reg_file.sv
logic/alu.sv
logic/data_ram.sv
logic/instr_ram.sv
logic/rv_step_core.sv
sim/tb_rv_step_core.sv

// ==== Makefile ====
TOP = tb_rv_step_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f rv_step_core.f \
		--top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Result: PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
